// ==== src.f ====
hw/fifo_buffer_pkg.sv
hw/fifo_push_side.sv
hw/memory_dp.sv
hw/fifo_pop_side.sv
hw/fifo_buffer.sv
tb/fifo_buffer_asserts.sv
tb/tb_fifo_buffer.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_fifo_buffer
FILELIST := src.f
FLAGS    := --binary --assert --top-module $(TOP)
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/tb_fifo_buffer.sv ====
// directed testbench for the fifo buffer; checks pops against memory and queue models
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_buffer;

   localparam int DEPTH = 16;                      // passed to the dut
   localparam int AW    = $clog2(DEPTH);

   logic                               clk;
   logic                               rst_n;
   logic                               push;
   fifo_buffer_pkg::push_req_t         push_req;
   logic                               pop;
   logic                               bist_en;
   fifo_buffer_pkg::bist_req_t         bist_req;
   logic [AW-1:0]                      bist_addr;
   logic                               full;
   logic                               empty;
   logic                               pop_valid;
   logic [fifo_buffer_pkg::DATA_W-1:0] pop_data;

   logic [31:0] mem_model [DEPTH];                 // expected storage
   logic [31:0] exp_q [$];                         // pushed, not yet popped
   int          wr_idx;                            // model write slot
   logic        last_pop_ok;                       // last cycle popped a word
   logic [31:0] last_word;                         // word due on pop_data
   integer      seed;
   int          err_cnt;
   int          pass_cnt;

   fifo_buffer #(.DEPTH(DEPTH)) i_fifo_buffer (
      .clk(clk), .rst_n(rst_n), .push(push), .push_req(push_req), .pop(pop),
      .bist_en(bist_en), .bist_req(bist_req), .bist_addr(bist_addr),
      .full(full), .empty(empty), .pop_valid(pop_valid), .pop_data(pop_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;                      // 20 ns period
   end

   // ##########################################################################
   // models and helpers
   // ##########################################################################

   // enabled bytes take the new word, the rest keep the old one
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  be);
      logic [31:0] res;
      res = old_word;
      for (int b = 0; b < 4; b++)
      begin
         if (be[b])
         begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      if (exp !== act)
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         err_cnt++;
      end
      else
      begin
         pass_cnt++;
      end
   endtask

   // drive one cycle at the falling edge, update the models, wait for the next falling edge
   task automatic run_cycle(input logic p, input logic [31:0] d, input logic [3:0] be,
                            input logic q);
      logic push_ok;
      logic pop_ok;
      push_ok       = p && !bist_en && (exp_q.size() < DEPTH);  // full drops it
      pop_ok        = q && (exp_q.size() > 0);                  // empty ignores it
      push          = p;
      push_req.data = d;
      push_req.be   = be;
      pop           = q;
      if (bist_en && bist_req.we)
      begin
         mem_model[bist_addr] = merge_bytes(mem_model[bist_addr], bist_req.data, bist_req.be);
      end
      last_pop_ok = pop_ok;
      if (pop_ok)
      begin
         last_word = exp_q.pop_front();
      end
      if (push_ok)
      begin
         mem_model[wr_idx] = merge_bytes(mem_model[wr_idx], d, be);
         exp_q.push_back(mem_model[wr_idx]);
         wr_idx = (wr_idx + 1) % DEPTH;
      end
      @(negedge clk);
   endtask

   task automatic pop_and_check(input string name);
      int waited;
      run_cycle(1'b0, 32'h0, 4'h0, 1'b1);
      pop    = 1'b0;                               // single pop
      waited = 0;
      while (pop_valid !== 1'b1 && waited < 8)
      begin
         @(negedge clk);
         waited++;
      end
      if (!last_pop_ok)
      begin
         $display("ERROR %s: pop issued while the model queue was empty", name);
         err_cnt++;
      end
      else if (pop_valid !== 1'b1)
      begin
         $display("ERROR %s: pop_valid never came after a pop", name);
         err_cnt++;
      end
      else
      begin
         compare_word(name, last_word, pop_data);
      end
   endtask

   // ##########################################################################
   // directed tests
   // ##########################################################################

   task automatic test_reset();
      int e0;
      e0 = err_cnt;
      compare_word("reset empty", 32'd1, 32'(empty));
      compare_word("reset full", 32'd0, 32'(full));
      compare_word("reset pop_valid", 32'd0, 32'(pop_valid));
      $display("test reset finished, %0d errors", err_cnt - e0);
   endtask

   task automatic test_fill_drain();
      int e0;
      e0 = err_cnt;
      for (int i = 0; i < DEPTH; i++)
      begin
         compare_word("fill full early", 32'd0, 32'(full));
         run_cycle(1'b1, $random(seed), 4'hf, 1'b0);
      end
      compare_word("fill full", 32'd1, 32'(full));
      run_cycle(1'b1, 32'hdead_beef, 4'hf, 1'b0);  // dropped
      compare_word("fill overflow full", 32'd1, 32'(full));
      for (int i = 0; i < DEPTH; i++)
      begin
         pop_and_check("fill drain");
      end
      compare_word("drain empty", 32'd1, 32'(empty));
      run_cycle(1'b0, 32'h0, 4'h0, 1'b1);          // pop while empty
      compare_word("empty pop_valid", 32'd0, 32'(pop_valid));
      run_cycle(1'b0, 32'h0, 4'h0, 1'b0);
      $display("test fill_drain finished, %0d errors", err_cnt - e0);
   endtask

   task automatic test_masked_merge();
      int e0;
      e0 = err_cnt;
      for (int i = 0; i < DEPTH; i++)
      begin
         run_cycle(1'b1, $random(seed), 4'($random(seed)), 1'b0);  // second lap
      end
      for (int i = 0; i < DEPTH; i++)
      begin
         pop_and_check("masked merge");
      end
      $display("test masked_merge finished, %0d errors", err_cnt - e0);
   endtask

   task automatic test_bist();
      int e0;
      e0      = err_cnt;
      bist_en = 1'b1;
      for (int k = 0; k < 3; k++)
      begin
         bist_addr = AW'(2 * k + 1);               // slots 1, 3, 5
         bist_req  = '{we: 1'b1, be: 4'hf, data: 32'($random(seed))};
         run_cycle(1'b1, 32'hffff_ffff, 4'hf, 1'b0);  // push ignored
      end
      bist_en  = 1'b0;
      bist_req = '0;
      push     = 1'b0;
      compare_word("bist empty", 32'd1, 32'(empty));
      for (int i = 0; i < 6; i++)
      begin
         run_cycle(1'b1, 32'h5a5a_5a5a, 4'h0, 1'b0);  // no byte enabled
      end
      for (int i = 0; i < 6; i++)
      begin
         pop_and_check("bist override");
      end
      $display("test bist finished, %0d errors", err_cnt - e0);
   endtask

   task automatic test_random();
      int   e0;
      logic p;
      logic q;
      e0 = err_cnt;
      for (int c = 0; c < 200; c++)
      begin
         p = (($random(seed) & 3) != 0);           // pushes lead, fifo fills up
         q = (($random(seed) & 1) != 0);
         run_cycle(p, $random(seed), 4'hf, q);
         compare_word("random pop_valid", 32'(last_pop_ok), 32'(pop_valid));
         if (last_pop_ok)
         begin
            compare_word("random data", last_word, pop_data);
         end
         compare_word("random full", 32'(exp_q.size() == DEPTH), 32'(full));
         compare_word("random empty", 32'(exp_q.size() == 0), 32'(empty));
      end
      run_cycle(1'b0, 32'h0, 4'h0, 1'b0);
      $display("test random finished, %0d errors", err_cnt - e0);
   endtask

   // ##########################################################################
   // sequence
   // ##########################################################################

   initial
   begin
      seed      = 22;
      err_cnt   = 0;
      pass_cnt  = 0;
      wr_idx    = 0;
      rst_n     = 1'b0;
      push      = 1'b0;
      push_req  = '0;
      pop       = 1'b0;
      bist_en   = 1'b0;
      bist_req  = '0;
      bist_addr = '0;
      repeat (8) @(posedge clk);                   // reset for 8 cycles
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      test_reset();
      test_fill_drain();
      test_masked_merge();
      test_bist();
      test_random();
      $display("checks passed %0d, errors %0d", pass_cnt, err_cnt);
      if (err_cnt == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/fifo_buffer_asserts.sv ====
// flag and pointer assertions for the fifo buffer, attached to every fifo_buffer by bind
`timescale 1ns/1ps
`default_nettype none

module fifo_buffer_asserts #(
   parameter int  DEPTH = 16,                      // follows the bound instance
   localparam int AW    = $clog2(DEPTH)
) (
   input wire logic        clk,
   input wire logic        rst_n,
   input wire logic        pop,
   input wire logic        bist_en,
   input wire logic        full,
   input wire logic        empty,
   input wire logic        pop_valid,
   input wire logic [AW:0] wr_ptr,                 // lap bit on top
   input wire logic [AW:0] rd_ptr                  // lap bit on top
);

   logic [AW:0] fill_level;                        // words stored, from the pointers

   assign fill_level = wr_ptr - rd_ptr;            // wraps with the lap bit

   a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(full && empty) && (fill_level <= DEPTH))
      else $error("full and empty are high together or the fifo holds more than DEPTH words");

   a_valid_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
      pop_valid |-> $past(pop && !empty))
      else $error("pop_valid without an accepted pop one cycle earlier");

   a_bist_holds_wr_ptr: assert property (@(posedge clk) disable iff (!rst_n)
      bist_en |=> $stable(wr_ptr))
      else $error("write pointer moved while bist_en was high");

   a_empty_holds_rd_ptr: assert property (@(posedge clk) disable iff (!rst_n)
      empty |=> $stable(rd_ptr))
      else $error("read pointer moved while the fifo was empty");

endmodule

bind fifo_buffer fifo_buffer_asserts #(.DEPTH(DEPTH)) i_fifo_buffer_asserts (
   .clk(clk), .rst_n(rst_n), .pop(pop), .bist_en(bist_en), .full(full), .empty(empty),
   .pop_valid(pop_valid), .wr_ptr(wr_ptr), .rd_ptr(rd_ptr)
);

`default_nettype wire

// ==== hw/fifo_buffer.sv ====
// top level of the single clock fifo buffer: push side, dual port memory, pop side
`timescale 1ns/1ps
`default_nettype none

module fifo_buffer #(
   parameter int  DEPTH = 16,                                 // fifo depth, power of two
   localparam int AW    = $clog2(DEPTH)                       // address width
) (
   input  wire logic                                clk,       // single clock
   input  wire logic                                rst_n,     // sync reset, active low
   input  wire logic                                push,      // push strobe
   input  wire fifo_buffer_pkg::push_req_t          push_req,  // push data and enables
   input  wire logic                                pop,       // pop strobe
   input  wire logic                                bist_en,   // bist takes the write port
   input  wire fifo_buffer_pkg::bist_req_t          bist_req,  // bist write request
   input  wire logic [AW-1:0]                       bist_addr, // bist address
   output logic                                     full,      // no room
   output logic                                     empty,     // nothing stored
   output logic                                     pop_valid, // popped word strobe
   output logic      [fifo_buffer_pkg::DATA_W-1:0]  pop_data   // popped word
);

   logic [AW:0]                        wr_ptr;   // write pointer, lap bit on top
   logic [AW:0]                        rd_ptr;   // read pointer, lap bit on top
   logic                               wr_en;    // memory write strobe
   logic [AW-1:0]                      wr_addr;  // memory write address
   fifo_buffer_pkg::mem_wr_t           mem_wr;   // memory write payload
   logic                               rd_en;    // memory read strobe
   logic [AW-1:0]                      rd_addr;  // memory read address
   logic [fifo_buffer_pkg::DATA_W-1:0] rd_dout;  // memory read data

   // ##########################################################################
   // write side, storage, read side
   // ##########################################################################

   fifo_push_side #(.DEPTH(DEPTH)) i_fifo_push_side (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .push_req  (push_req),
      .bist_en   (bist_en),
      .bist_req  (bist_req),
      .bist_addr (bist_addr),
      .rd_ptr    (rd_ptr),
      .wr_ptr    (wr_ptr),
      .full      (full),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .mem_wr    (mem_wr)
   );

   memory_dp #(.DEPTH(DEPTH)) i_memory_dp (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .mem_wr  (mem_wr),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_dout (rd_dout)
   );

   fifo_pop_side #(.DEPTH(DEPTH)) i_fifo_pop_side (
      .clk       (clk),
      .rst_n     (rst_n),
      .pop       (pop),
      .wr_ptr    (wr_ptr),
      .rd_ptr    (rd_ptr),
      .empty     (empty),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_dout   (rd_dout),
      .pop_valid (pop_valid),
      .pop_data  (pop_data)
   );

endmodule

`default_nettype wire

// ==== hw/fifo_pop_side.sv ====
// fifo read side: owns read pointer and empty flag, issues reads, flags popped words
`timescale 1ns/1ps
`default_nettype none

module fifo_pop_side #(
   parameter int  DEPTH = 16,                                 // fifo depth, power of two
   localparam int AW    = $clog2(DEPTH)                       // address width
) (
   input  wire logic                                clk,      // single clock
   input  wire logic                                rst_n,    // sync reset, active low
   input  wire logic                                pop,      // pop strobe
   // pointer exchange
   input  wire logic [AW:0]                         wr_ptr,   // from push side
   output logic      [AW:0]                         rd_ptr,   // to push side
   output logic                                     empty,    // nothing stored
   // memory read port
   output logic                                     rd_en,    // read strobe
   output logic      [AW-1:0]                       rd_addr,  // read address
   input  wire logic [fifo_buffer_pkg::DATA_W-1:0]  rd_dout,  // registered memory word
   // popped word
   output logic                                     pop_valid, // one cycle pulse
   output logic      [fifo_buffer_pkg::DATA_W-1:0]  pop_data   // word for that pulse
);

   // ##########################################################################
   // flags and accept
   // ##########################################################################

   assign empty = (rd_ptr == wr_ptr);                         // same slot, same lap

   assign rd_en   = pop && !empty;                            // pop while empty ignored
   assign rd_addr = rd_ptr[AW-1:0];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_ptr <= '0;
      end
      else if (rd_en)
      begin
         rd_ptr <= rd_ptr + 1'b1;                             // advance with the read
      end
   end

   // ##########################################################################
   // output
   // ##########################################################################

   // valid lines up with the memory output register
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pop_valid <= 1'b0;
      end
      else
      begin
         pop_valid <= rd_en;
      end
   end

   assign pop_data = rd_dout;                                 // already registered

endmodule

`default_nettype wire

// ==== hw/memory_dp.sv ====
// dual port word memory with per bit write mask and registered read, no reset on contents
`timescale 1ns/1ps
`default_nettype none

module memory_dp #(
   parameter int  DEPTH = 16,                                 // number of words
   localparam int AW    = $clog2(DEPTH)                       // address width
) (
   input  wire logic                                clk,      // shared clock
   // write port
   input  wire logic                                wr_en,    // write strobe
   input  wire logic [AW-1:0]                       wr_addr,  // write address
   input  wire fifo_buffer_pkg::mem_wr_t            mem_wr,   // mask and data
   // read port
   input  wire logic                                rd_en,    // read strobe
   input  wire logic [AW-1:0]                       rd_addr,  // read address
   output logic      [fifo_buffer_pkg::DATA_W-1:0]  rd_dout   // registered read data
);

   logic [fifo_buffer_pkg::DATA_W-1:0] mem [DEPTH];          // storage array

   // ##########################################################################
   // write port
   // ##########################################################################

   // masked bits keep the old contents
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= (mem[wr_addr] & ~mem_wr.wem) | (mem_wr.din & mem_wr.wem);
      end
   end

   // ##########################################################################
   // read port
   // ##########################################################################

   // old data on a same-address collision
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         rd_dout <= mem[rd_addr];                             // holds when idle
      end
   end

endmodule

`default_nettype wire

// ==== hw/fifo_push_side.sv ====
// fifo write side: owns write pointer and full flag, builds the bit mask, muxes in bist writes
`timescale 1ns/1ps
`default_nettype none

module fifo_push_side #(
   parameter int  DEPTH = 16,                         // fifo depth, power of two
   localparam int AW    = $clog2(DEPTH)               // address width
) (
   input  wire logic                       clk,       // single clock
   input  wire logic                       rst_n,     // sync reset, active low
   // push request
   input  wire logic                       push,      // push strobe
   input  wire fifo_buffer_pkg::push_req_t push_req,  // push data and byte enables
   // bist write port
   input  wire logic                       bist_en,   // bist owns the write port
   input  wire fifo_buffer_pkg::bist_req_t bist_req,  // bist strobe, enables, data
   input  wire logic [AW-1:0]              bist_addr, // bist address
   // pointer exchange
   input  wire logic [AW:0]                rd_ptr,    // from pop side, with wrap bit
   output logic      [AW:0]                wr_ptr,    // to pop side, with wrap bit
   output logic                            full,      // no room left
   // memory write port
   output logic                            wr_en,     // write strobe
   output logic      [AW-1:0]              wr_addr,   // write address
   output fifo_buffer_pkg::mem_wr_t        mem_wr     // mask and data
);

   logic                                 fifo_wr;     // accepted push
   logic [fifo_buffer_pkg::BE_W-1:0]     be_sel;      // enables of the selected source
   logic [fifo_buffer_pkg::DATA_W-1:0]   wem_bits;    // expanded mask

   // ##########################################################################
   // flags and accept
   // ##########################################################################

   // same slot, opposite lap
   assign full = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

   assign fifo_wr = push && !full && !bist_en;      // push while full is dropped

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
      end
      else if (fifo_wr)
      begin
         wr_ptr <= wr_ptr + 1'b1;                   // wraps into the lap bit
      end
   end

   // ##########################################################################
   // write port select and mask expansion
   // ##########################################################################

   assign be_sel = bist_en ? bist_req.be : push_req.be;

   // each byte enable covers eight bits
   always_comb
   begin
      for (int i = 0; i < fifo_buffer_pkg::BE_W; i++)
      begin
         wem_bits[8*i +: 8] = {8{be_sel[i]}};
      end
   end

   assign wr_en      = bist_en ? bist_req.we : fifo_wr;
   assign wr_addr    = bist_en ? bist_addr : wr_ptr[AW-1:0];
   assign mem_wr.wem = wem_bits;
   assign mem_wr.din = bist_en ? bist_req.data : push_req.data;

endmodule

`default_nettype wire

// ==== hw/fifo_buffer_pkg.sv ====
// shared widths and packed request structs for the fifo buffer; referenced by scoped name
`default_nettype none

package fifo_buffer_pkg;

   // ##########################################################################
   // widths
   // ##########################################################################

   localparam int DATA_W = 32;          // word width
   localparam int BE_W   = DATA_W / 8;  // one enable per byte

   // ##########################################################################
   // request and payload structs
   // ##########################################################################

   // push payload from the top level
   typedef struct packed {
      logic [DATA_W-1:0] data;          // word to push
      logic [BE_W-1:0]   be;            // byte enables
   } push_req_t;

   // bist write, address travels separately (width follows DEPTH)
   typedef struct packed {
      logic              we;            // bist write strobe
      logic [BE_W-1:0]   be;            // byte enables
      logic [DATA_W-1:0] data;          // bist data word
   } bist_req_t;

   // single write port payload into the memory
   typedef struct packed {
      logic [DATA_W-1:0] wem;           // per bit write mask
      logic [DATA_W-1:0] din;           // write data
   } mem_wr_t;

endpackage

`default_nettype wire
